//--- hdl/clip_geom_pkg.sv
`default_nettype none

package clip_geom_pkg;

    typedef logic signed [15:0] coord_t;        // vertex coordinate as given
    typedef logic [9:0]         screen_coord_t; // coordinate on the raster
    typedef logic [7:0]         color_t;
    typedef logic [2:0]         out_color_t;    // raster takes 3 colour bits

    // ymax, ymin, xmax, xmin from the top bit
    typedef logic [3:0] outcode_t;

    typedef enum logic [1:0] {
        SHAPE_POINT = 2'd0,
        SHAPE_LINE  = 2'd1,
        SHAPE_TRI   = 2'd2,
        SHAPE_QUAD  = 2'd3
    } shape_e;

    // window, bounds themselves are visible
    localparam coord_t X_MIN = 16'sd0;
    localparam coord_t X_MAX = 16'sd640;
    localparam coord_t Y_MIN = 16'sd0;
    localparam coord_t Y_MAX = 16'sd480;

endpackage

`default_nettype wire

//--- hdl/clip_ctrl_pkg.sv
`default_nettype none

package clip_ctrl_pkg;

    typedef enum logic [1:0] {
        SPLIT_IDLE,
        SPLIT_EMIT,
        SPLIT_WAIT   // gap while clip busy rises
    } split_state_e;

    typedef enum logic [2:0] {
        CLIP_IDLE,
        CLIP_TEST,
        CLIP_DIV,
        CLIP_LOAD,
        CLIP_DONE
    } clip_state_e;

    // boundaries are walked in this order
    typedef enum logic [1:0] {B_YMAX, B_YMIN, B_XMAX, B_XMIN} boundary_e;

    localparam int DIV_BITS = 16; // quotient bits, one per divider cycle

endpackage

`default_nettype wire

//--- hdl/shape_splitter.sv
`default_nettype none

module shape_splitter import clip_geom_pkg::*, clip_ctrl_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   obj_valid,
    input  shape_e obj_shape,
    input  coord_t obj_x0,
    input  coord_t obj_y0,
    input  coord_t obj_x1,
    input  coord_t obj_y1,
    input  coord_t obj_x2,
    input  coord_t obj_y2,
    input  coord_t obj_x3,
    input  coord_t obj_y3,
    input  color_t obj_color,
    input  logic   clip_busy,
    output logic   seg_start,
    output coord_t seg_x0,
    output coord_t seg_y0,
    output coord_t seg_x1,
    output coord_t seg_y1,
    output color_t seg_color,
    output logic   busy
);

    split_state_e state;
    shape_e       shape;
    coord_t       vx [4];
    coord_t       vy [4];
    logic [1:0]   edge_idx; // current edge, also its start vertex
    logic [1:0]   last_idx;
    logic [1:0]   end_idx;
    logic         accept;

    assign busy   = (state != SPLIT_IDLE) | clip_busy;
    assign accept = obj_valid & ~busy; // strobes while busy are dropped

    always_comb begin
        case (shape)
            SHAPE_TRI:  last_idx = 2'd2;
            SHAPE_QUAD: last_idx = 2'd3;
            default:    last_idx = 2'd0; // point and line have one edge
        endcase
        if (shape == SHAPE_LINE)
            end_idx = 2'd1;
        else if (edge_idx == last_idx)
            end_idx = 2'd0;              // closing edge back to v0
        else
            end_idx = edge_idx + 2'd1;
    end

    assign seg_x0 = vx[edge_idx];
    assign seg_y0 = vy[edge_idx];
    assign seg_x1 = vx[end_idx];
    assign seg_y1 = vy[end_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SPLIT_IDLE;
            edge_idx  <= 2'd0;
            seg_start <= 1'b0;
        end else begin
            seg_start <= 1'b0;
            case (state)
                SPLIT_IDLE: if (accept) begin
                    edge_idx  <= 2'd0;
                    seg_start <= 1'b1; // first edge right away
                    state     <= SPLIT_WAIT;
                end
                SPLIT_EMIT: if (!clip_busy) begin
                    seg_start <= 1'b1;
                    state     <= SPLIT_WAIT;
                end
                SPLIT_WAIT: begin
                    if (edge_idx == last_idx) begin
                        state <= SPLIT_IDLE;
                    end else begin
                        edge_idx <= edge_idx + 2'd1;
                        state    <= SPLIT_EMIT;
                    end
                end
                default: state <= SPLIT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            shape     <= obj_shape;
            vx[0]     <= obj_x0;
            vy[0]     <= obj_y0;
            vx[1]     <= obj_x1;
            vy[1]     <= obj_y1;
            vx[2]     <= obj_x2;
            vy[2]     <= obj_y2;
            vx[3]     <= obj_x3;
            vy[3]     <= obj_y3;
            seg_color <= obj_color;
        end
    end

endmodule

`default_nettype wire

//--- hdl/seq_divider.sv
`default_nettype none

module seq_divider import clip_geom_pkg::*, clip_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic signed [31:0] dividend,
    input  coord_t             divisor,
    output logic               done,
    output coord_t             quotient
);

    localparam int CNT_W = $clog2(DIV_BITS + 1);

    logic [CNT_W-1:0] cnt;      // steps left
    logic [15:0]      rem;      // partial remainder, stays below the divisor
    logic [15:0]      shreg;    // low dividend bits in, quotient bits out
    logic [15:0]      dsr_mag;
    logic             neg;      // sign of the result
    logic [31:0]      dvd_mag;
    logic [16:0]      rem_sh;
    logic             q_bit;
    logic [15:0]      rem_nxt;
    logic [15:0]      shreg_nxt;

    assign dvd_mag   = dividend[31] ? -dividend : dividend;
    assign rem_sh    = {rem, shreg[15]};
    assign q_bit     = (rem_sh >= {1'b0, dsr_mag});
    assign rem_nxt   = q_bit ? 16'(rem_sh - {1'b0, dsr_mag}) : rem_sh[15:0];
    assign shreg_nxt = {shreg[14:0], q_bit};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                cnt <= CNT_W'(DIV_BITS);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
                if (cnt == CNT_W'(1))
                    done <= 1'b1;          // lands DIV_BITS+1 after start
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem     <= dvd_mag[31:16];
            shreg   <= dvd_mag[15:0];
            dsr_mag <= divisor[15] ? -divisor : divisor;
            neg     <= dividend[31] ^ divisor[15];
        end else if (cnt != '0) begin
            rem   <= rem_nxt;
            shreg <= shreg_nxt;
            // sign applied to the magnitude, so result truncates toward zero
            if (cnt == CNT_W'(1))
                quotient <= neg ? -shreg_nxt : shreg_nxt;
        end
    end

endmodule

`default_nettype wire

//--- hdl/endpoint_clipper.sv
`default_nettype none

module endpoint_clipper import clip_geom_pkg::*, clip_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     seg_start,
    input  coord_t   own_x,
    input  coord_t   own_y,
    input  coord_t   far_x,
    input  coord_t   far_y,
    output logic     ep_done,
    output coord_t   ep_x,
    output coord_t   ep_y,
    output outcode_t ep_code,
    output logic     ep_miss
);

    clip_state_e        state;
    boundary_e          bnd;
    coord_t             px;
    coord_t             py;
    coord_t             fx;
    coord_t             fy;
    logic               zero_div; // a needed crossing had no slope
    logic               load_line;
    logic               last_bnd;
    outcode_t           cur_code;
    logic               y_edge;
    logic               breaks;
    coord_t             bound;
    coord_t             span;     // far minus own along the moving axis
    coord_t             offset;   // bound minus own along the crossed axis
    coord_t             dsr;
    logic signed [31:0] product;
    logic               div_start;
    logic               div_done;
    coord_t             quotient;

    function automatic outcode_t outcode(coord_t x, coord_t y);
        return {y > Y_MAX, y < Y_MIN, x > X_MAX, x < X_MIN};
    endfunction

    assign load_line = seg_start && (state == CLIP_IDLE);
    assign last_bnd  = (bnd == B_XMIN);
    assign cur_code  = outcode(px, py); // current position, not the arrival code

    always_comb begin
        case (bnd)
            B_YMAX: begin y_edge = 1'b1; bound = Y_MAX; breaks = cur_code[3]; end
            B_YMIN: begin y_edge = 1'b1; bound = Y_MIN; breaks = cur_code[2]; end
            B_XMAX: begin y_edge = 1'b0; bound = X_MAX; breaks = cur_code[1]; end
            default: begin y_edge = 1'b0; bound = X_MIN; breaks = cur_code[0]; end
        endcase
    end

    assign span      = y_edge ? fx - px : fy - py;
    assign offset    = y_edge ? bound - py : bound - px;
    assign dsr       = y_edge ? fy - py : fx - px;
    assign product   = span * offset;
    assign div_start = (state == CLIP_TEST) && breaks && (dsr != '0);

    seq_divider u_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (div_start),
        .dividend (product),
        .divisor  (dsr),
        .done     (div_done),
        .quotient (quotient)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= CLIP_IDLE;
            bnd      <= B_YMAX;
            zero_div <= 1'b0;
        end else begin
            case (state)
                CLIP_IDLE: if (load_line) begin
                    state    <= CLIP_TEST;
                    bnd      <= B_YMAX;
                    zero_div <= 1'b0;
                end
                CLIP_TEST: begin
                    if (div_start) begin
                        state <= CLIP_DIV;
                    end else begin
                        if (breaks)
                            zero_div <= 1'b1; // outside but parallel to the edge
                        if (last_bnd) state <= CLIP_DONE;
                        else bnd <= boundary_e'(bnd + 2'd1);
                    end
                end
                CLIP_DIV: if (div_done) state <= CLIP_LOAD;
                CLIP_LOAD: begin
                    if (last_bnd) state <= CLIP_DONE;
                    else begin
                        state <= CLIP_TEST;
                        bnd   <= boundary_e'(bnd + 2'd1);
                    end
                end
                default: state <= CLIP_IDLE;  // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_line) begin
            px      <= own_x;
            py      <= own_y;
            fx      <= far_x;
            fy      <= far_y;
            ep_code <= outcode(own_x, own_y);
        end else if (state == CLIP_LOAD) begin
            if (y_edge) begin
                px <= px + quotient;
                py <= bound;
            end else begin
                py <= py + quotient;
                px <= bound;
            end
        end
    end

    assign ep_done = (state == CLIP_DONE);
    assign ep_x    = px;
    assign ep_y    = py;
    assign ep_miss = zero_div | (cur_code != '0); // held until the next line

endmodule

`default_nettype wire

//--- hdl/line_combiner.sv
`default_nettype none

module line_combiner import clip_geom_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          seg_start,
    input  color_t        seg_color,
    input  logic          done0,
    input  logic          done1,
    input  coord_t        x0,
    input  coord_t        y0,
    input  coord_t        x1,
    input  coord_t        y1,
    input  outcode_t      code0,
    input  outcode_t      code1,
    input  logic          miss0,
    input  logic          miss1,
    output logic          clip_busy,
    output logic          line_valid,
    output screen_coord_t x0_out,
    output screen_coord_t y0_out,
    output screen_coord_t x1_out,
    output screen_coord_t y1_out,
    output out_color_t    color_out
);

    color_t color_q;
    logic   seen0;     // endpoint 0 already finished
    logic   seen1;
    logic   both_done;
    logic   keep;
    logic   decided;   // line_valid cycle, with or without a line

    assign both_done = (done0 | seen0) & (done1 | seen1);
    // trivial reject on a shared outside region
    assign keep      = ((code0 & code1) == '0) & ~miss0 & ~miss1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen0      <= 1'b0;
            seen1      <= 1'b0;
            decided    <= 1'b0;
            line_valid <= 1'b0;
            clip_busy  <= 1'b0;
        end else begin
            if (both_done) begin
                seen0 <= 1'b0;
                seen1 <= 1'b0;
            end else begin
                if (done0) seen0 <= 1'b1;
                if (done1) seen1 <= 1'b1;
            end
            decided    <= both_done;
            line_valid <= both_done & keep;
            if (seg_start)
                clip_busy <= 1'b1;
            else if (decided)
                clip_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (seg_start)
            color_q <= seg_color;
        if (both_done) begin
            x0_out    <= x0[9:0];  // in window, fits 10 bits
            y0_out    <= y0[9:0];
            x1_out    <= x1[9:0];
            y1_out    <= y1[9:0];
            color_out <= color_q[2:0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/clip_top.sv
`default_nettype none

module clip_top import clip_geom_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          obj_valid,
    input  shape_e        obj_shape,
    input  coord_t        obj_x0,
    input  coord_t        obj_y0,
    input  coord_t        obj_x1,
    input  coord_t        obj_y1,
    input  coord_t        obj_x2,
    input  coord_t        obj_y2,
    input  coord_t        obj_x3,
    input  coord_t        obj_y3,
    input  color_t        obj_color,
    output logic          busy,
    output logic          line_valid,
    output screen_coord_t x0_out,
    output screen_coord_t y0_out,
    output screen_coord_t x1_out,
    output screen_coord_t y1_out,
    output out_color_t    color_out
);

    logic     seg_start;
    logic     clip_busy;
    coord_t   seg_x0;
    coord_t   seg_y0;
    coord_t   seg_x1;
    coord_t   seg_y1;
    color_t   seg_color;
    logic     done0;
    logic     done1;
    coord_t   ep0_x;
    coord_t   ep0_y;
    coord_t   ep1_x;
    coord_t   ep1_y;
    outcode_t code0;
    outcode_t code1;
    logic     miss0;
    logic     miss1;

    shape_splitter u_split (
        .clk       (clk),
        .rst_n     (rst_n),
        .obj_valid (obj_valid),
        .obj_shape (obj_shape),
        .obj_x0    (obj_x0),
        .obj_y0    (obj_y0),
        .obj_x1    (obj_x1),
        .obj_y1    (obj_y1),
        .obj_x2    (obj_x2),
        .obj_y2    (obj_y2),
        .obj_x3    (obj_x3),
        .obj_y3    (obj_y3),
        .obj_color (obj_color),
        .clip_busy (clip_busy),
        .seg_start (seg_start),
        .seg_x0    (seg_x0),
        .seg_y0    (seg_y0),
        .seg_x1    (seg_x1),
        .seg_y1    (seg_y1),
        .seg_color (seg_color),
        .busy      (busy)
    );

    // endpoint 0 moves (x0,y0) toward (x1,y1)
    endpoint_clipper ep0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .seg_start (seg_start),
        .own_x     (seg_x0),
        .own_y     (seg_y0),
        .far_x     (seg_x1),
        .far_y     (seg_y1),
        .ep_done   (done0),
        .ep_x      (ep0_x),
        .ep_y      (ep0_y),
        .ep_code   (code0),
        .ep_miss   (miss0)
    );

    endpoint_clipper ep1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .seg_start (seg_start),
        .own_x     (seg_x1),  // roles swapped
        .own_y     (seg_y1),
        .far_x     (seg_x0),
        .far_y     (seg_y0),
        .ep_done   (done1),
        .ep_x      (ep1_x),
        .ep_y      (ep1_y),
        .ep_code   (code1),
        .ep_miss   (miss1)
    );

    line_combiner u_comb (
        .clk        (clk),
        .rst_n      (rst_n),
        .seg_start  (seg_start),
        .seg_color  (seg_color),
        .done0      (done0),
        .done1      (done1),
        .x0         (ep0_x),
        .y0         (ep0_y),
        .x1         (ep1_x),
        .y1         (ep1_y),
        .code0      (code0),
        .code1      (code1),
        .miss0      (miss0),
        .miss1      (miss1),
        .clip_busy  (clip_busy),
        .line_valid (line_valid),
        .x0_out     (x0_out),
        .y0_out     (y0_out),
        .x1_out     (x1_out),
        .y1_out     (y1_out),
        .color_out  (color_out)
    );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk; // free running

endmodule

`default_nettype wire

//--- tests/clip_assertions.sv
`default_nettype none

module clip_assertions import clip_geom_pkg::*; (
    input logic          clk,
    input logic          rst_n,
    input logic          busy,
    input logic          line_valid,
    input screen_coord_t x0_out,
    input screen_coord_t y0_out,
    input screen_coord_t x1_out,
    input screen_coord_t y1_out
);

    // sampled on the falling edge so the first reset edge has already passed
    reset_quiet: assert property (@(negedge clk) !rst_n |-> !busy && !line_valid)
        else $error("busy or line_valid high during reset");

    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        line_valid |=> !line_valid)
        else $error("line_valid held for more than one cycle");

    // unsigned outputs, only the upper bounds can break
    in_window: assert property (@(posedge clk) disable iff (!rst_n)
        line_valid |-> (x0_out <= X_MAX) && (x1_out <= X_MAX)
                    && (y0_out <= Y_MAX) && (y1_out <= Y_MAX))
        else $error("emitted coordinate outside the window");

endmodule

`default_nettype wire

//--- tests/clip_tb.sv
`default_nettype none

module clip_tb import clip_geom_pkg::*; ();

    localparam int WAIT_LIMIT = 4000; // cycles per wait
    localparam int MAX_TRIES  = 20;

    typedef struct packed {
        screen_coord_t x0;
        screen_coord_t y0;
        screen_coord_t x1;
        screen_coord_t y1;
        out_color_t    color;
    } exp_line_t;

    logic          clk;
    logic          rst_n;
    logic          obj_valid;
    shape_e        obj_shape;
    coord_t        obj_x0;
    coord_t        obj_y0;
    coord_t        obj_x1;
    coord_t        obj_y1;
    coord_t        obj_x2;
    coord_t        obj_y2;
    coord_t        obj_x3;
    coord_t        obj_y3;
    color_t        obj_color;
    logic          busy;
    logic          line_valid;
    screen_coord_t x0_out;
    screen_coord_t y0_out;
    screen_coord_t x1_out;
    screen_coord_t y1_out;
    out_color_t    color_out;

    int        seed;
    int        errors;
    int        checks;
    int        lines_seen;
    int        lines_expected;
    logic      timed_out;
    exp_line_t expected_q[$];
    exp_line_t next_line;

    // object under construction
    shape_e    cur_shape;
    color_t    cur_color;
    coord_t    vx [4];
    coord_t    vy [4];

    tb_clk_gen u_clk (.clk(clk));

    clip_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .obj_valid  (obj_valid),
        .obj_shape  (obj_shape),
        .obj_x0     (obj_x0),
        .obj_y0     (obj_y0),
        .obj_x1     (obj_x1),
        .obj_y1     (obj_y1),
        .obj_x2     (obj_x2),
        .obj_y2     (obj_y2),
        .obj_x3     (obj_x3),
        .obj_y3     (obj_y3),
        .obj_color  (obj_color),
        .busy       (busy),
        .line_valid (line_valid),
        .x0_out     (x0_out),
        .y0_out     (y0_out),
        .x1_out     (x1_out),
        .y1_out     (y1_out),
        .color_out  (color_out)
    );

    bind clip_top clip_assertions u_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .busy       (busy),
        .line_valid (line_valid),
        .x0_out     (x0_out),
        .y0_out     (y0_out),
        .x1_out     (x1_out),
        .y1_out     (y1_out)
    );

    function automatic int rand_range(int lo, int hi);
        int r;
        r = $random(seed);
        r = r & 32'h7fff_ffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    // ymax, ymin, xmax, xmin from the top bit
    function automatic outcode_t region(coord_t x, coord_t y);
        region = 4'b0000;
        if (y > Y_MAX) region[3] = 1'b1;
        if (y < Y_MIN) region[2] = 1'b1;
        if (x > X_MAX) region[1] = 1'b1;
        if (x < X_MIN) region[0] = 1'b1;
    endfunction

    function automatic int edge_count(shape_e s);
        case (s)
            SHAPE_TRI:  return 3;
            SHAPE_QUAD: return 4;
            default:    return 1;
        endcase
    endfunction

    // walks one endpoint over ymax, ymin, xmax, xmin from its current position
    task automatic model_endpoint(input coord_t ox, input coord_t oy,
                                  input coord_t fx, input coord_t fy,
                                  output coord_t rx, output coord_t ry,
                                  output outcode_t code, output logic miss,
                                  output logic wide);
        coord_t             px;
        coord_t             py;
        coord_t             bound;
        coord_t             span;
        coord_t             off;
        coord_t             dv;
        logic signed [31:0] num;
        logic signed [31:0] q;
        logic               y_edge;
        logic               outside;
        px   = ox;
        py   = oy;
        code = region(ox, oy);
        miss = 1'b0;
        wide = 1'b0;
        for (int b = 0; b < 4; b++) begin
            case (b)
                0: begin
                    y_edge  = 1'b1;
                    bound   = Y_MAX;
                    outside = (py > Y_MAX);
                end
                1: begin
                    y_edge  = 1'b1;
                    bound   = Y_MIN;
                    outside = (py < Y_MIN);
                end
                2: begin
                    y_edge  = 1'b0;
                    bound   = X_MAX;
                    outside = (px > X_MAX);
                end
                default: begin
                    y_edge  = 1'b0;
                    bound   = X_MIN;
                    outside = (px < X_MIN);
                end
            endcase
            if (outside) begin
                dv   = y_edge ? fy - py : fx - px;
                span = y_edge ? fx - px : fy - py;
                off  = y_edge ? bound - py : bound - px;
                if (dv == 0) begin
                    miss = 1'b1;
                end else begin
                    num = 32'(span) * 32'(off);
                    q   = num / 32'(dv);           // truncates toward zero
                    if (q > 32767 || q < -32767)
                        wide = 1'b1;               // quotient leaves coord_t
                    if (y_edge) begin
                        px = px + coord_t'(q);
                        py = bound;
                    end else begin
                        py = py + coord_t'(q);
                        px = bound;
                    end
                end
            end
        end
        rx = px;
        ry = py;
        if (region(px, py) != 4'b0000)
            miss = 1'b1;
    endtask

    // splits the current object and queues every visible line
    task automatic model_object(input logic commit, output logic wide_any);
        coord_t    x0;
        coord_t    y0;
        coord_t    x1;
        coord_t    y1;
        outcode_t  c0;
        outcode_t  c1;
        logic      m0;
        logic      m1;
        logic      w0;
        logic      w1;
        int        b;
        exp_line_t e;
        wide_any = 1'b0;
        for (int i = 0; i < edge_count(cur_shape); i++) begin
            if (cur_shape == SHAPE_LINE)
                b = 1;
            else if (i == edge_count(cur_shape) - 1)
                b = 0;                             // closing edge, also the point case
            else
                b = i + 1;
            model_endpoint(vx[i], vy[i], vx[b], vy[b], x0, y0, c0, m0, w0);
            model_endpoint(vx[b], vy[b], vx[i], vy[i], x1, y1, c1, m1, w1);
            wide_any = wide_any | w0 | w1;
            if (commit && (c0 & c1) == 4'b0000 && !m0 && !m1) begin
                e.x0    = x0[9:0];
                e.y0    = y0[9:0];
                e.x1    = x1[9:0];
                e.y1    = y1[9:0];
                e.color = cur_color[2:0];
                expected_q.push_back(e);
                lines_expected++;
            end
        end
    endtask

    task automatic check_line(input screen_coord_t got_x0, got_y0, got_x1, got_y1,
                              input out_color_t got_color,
                              input screen_coord_t exp_x0, exp_y0, exp_x1, exp_y1,
                              input out_color_t exp_color);
        string got_s;
        string exp_s;
        checks++;
        if (got_x0 !== exp_x0 || got_y0 !== exp_y0 || got_x1 !== exp_x1
                || got_y1 !== exp_y1 || got_color !== exp_color) begin
            errors++;
            got_s = $sformatf("(%0d,%0d)-(%0d,%0d) colour %0d",
                              got_x0, got_y0, got_x1, got_y1, got_color);
            exp_s = $sformatf("(%0d,%0d)-(%0d,%0d) colour %0d",
                              exp_x0, exp_y0, exp_x1, exp_y1, exp_color);
            $display("FAILED at %0t: line %0d is %s, expected %s", $time, lines_seen,
                     got_s, exp_s);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (busy !== 1'b0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy !== 1'b0) begin
            $display("timeout: busy stayed high while waiting for %s", what);
            timed_out = 1'b1;
        end
    endtask

    task automatic draw_vertices(input int xlo, input int xhi, input int ylo, input int yhi);
        for (int i = 0; i < 4; i++) begin
            vx[i] = coord_t'(rand_range(xlo, xhi));
            vy[i] = coord_t'(rand_range(ylo, yhi));
        end
    endtask

    // kind 0 point inside, 1 polygon inside, 2 shared region, 3 crossing line, 4 any
    task automatic draw_object(input int kind);
        cur_color = color_t'(rand_range(0, 255));
        draw_vertices(-1024, 2047, -1024, 2047);
        case (kind)
            0: begin
                cur_shape = SHAPE_POINT;
                vx[0]     = coord_t'(rand_range(X_MIN, X_MAX));
                vy[0]     = coord_t'(rand_range(Y_MIN, Y_MAX));
            end
            1: begin
                cur_shape = rand_range(0, 1) ? SHAPE_QUAD : SHAPE_TRI;
                draw_vertices(X_MIN, X_MAX, Y_MIN, Y_MAX);
            end
            2: begin
                cur_shape = SHAPE_LINE;
                case (rand_range(0, 3))
                    0:       draw_vertices(-1024, 2047, Y_MAX + 1, 2047);
                    1:       draw_vertices(-1024, 2047, -1024, Y_MIN - 1);
                    2:       draw_vertices(X_MAX + 1, 2047, -1024, 2047);
                    default: draw_vertices(-1024, X_MIN - 1, -1024, 2047);
                endcase
            end
            3: begin
                cur_shape = SHAPE_LINE;
                if (rand_range(0, 1) == 1) begin  // else both ends free
                    vx[0] = coord_t'(rand_range(X_MIN, X_MAX));
                    vy[0] = coord_t'(rand_range(Y_MIN, Y_MAX));
                end
            end
            default: cur_shape = shape_e'(2'(rand_range(0, 3)));
        endcase
    endtask

    // redraws until no division leaves the coordinate range
    task automatic draw_safe_object(input int kind);
        logic wide;
        int   tries;
        tries = 0;
        do begin
            draw_object(kind);
            model_object(1'b0, wide);
            tries++;
        end while (wide && tries < MAX_TRIES);
        if (wide) begin
            cur_shape = SHAPE_POINT;
            vx[0]     = 16'sd320;
            vy[0]     = 16'sd240;
        end
    endtask

    task automatic send_object(input logic junk_strobe);
        wait_idle("the splitter before a strobe");
        if (!timed_out) begin
            @(posedge clk);
            #10;
            obj_valid = 1'b1;
            obj_shape = cur_shape;
            obj_color = cur_color;
            obj_x0 = vx[0];
            obj_y0 = vy[0];
            obj_x1 = vx[1];
            obj_y1 = vy[1];
            obj_x2 = vx[2];
            obj_y2 = vy[2];
            obj_x3 = vx[3];
            obj_y3 = vy[3];
            @(posedge clk);                        // taken on this edge
            #10;
            if (junk_strobe) begin
                obj_shape = SHAPE_QUAD;            // all four edges visible if it got in
                obj_x0 = coord_t'(rand_range(X_MIN, X_MAX));
                obj_y0 = coord_t'(rand_range(Y_MIN, Y_MAX));
                obj_x1 = coord_t'(rand_range(X_MIN, X_MAX));
                obj_y1 = coord_t'(rand_range(Y_MIN, Y_MAX));
                obj_x2 = coord_t'(rand_range(X_MIN, X_MAX));
                obj_y2 = coord_t'(rand_range(Y_MIN, Y_MAX));
                obj_x3 = coord_t'(rand_range(X_MIN, X_MAX));
                obj_y3 = coord_t'(rand_range(Y_MIN, Y_MAX));
                obj_color = ~cur_color;
                @(posedge clk);
                #10;
                @(posedge clk);
                #10;
            end
            obj_valid = 1'b0;
        end
    endtask

    task automatic run_test(input string name, input int kind, input int count,
                            input int junk_every);
        int   err0;
        int   exp0;
        int   seen0;
        logic wide;
        err0  = errors;
        exp0  = lines_expected;
        seen0 = lines_seen;
        for (int n = 0; n < count && !timed_out; n++) begin
            draw_safe_object(kind);
            model_object(1'b1, wide);
            send_object(junk_every != 0 && (n % junk_every) == junk_every - 1);
            if (!timed_out)
                wait_idle("the lines of an object to drain");
        end
        if (!timed_out) begin
            check_count({name, " line count"}, lines_seen - seen0, lines_expected - exp0);
            if (kind == 2)
                check_count({name, " lines out"}, lines_seen - seen0, 0);
        end
        $display("%s: %0d objects, %0d lines, %s", name, count, lines_seen - seen0,
                 timed_out ? "timeout" : (errors == err0) ? "ok" : "mismatch");
    endtask

    // pops the expected queue on every line that leaves the DUT
    always @(negedge clk) begin
        if (rst_n === 1'b1 && line_valid === 1'b1) begin
            lines_seen++;
            if (expected_q.size() == 0) begin
                errors++;
                $display("FAILED at %0t: line %0d came out with none expected", $time,
                         lines_seen);
            end else begin
                next_line = expected_q.pop_front();
                check_line(x0_out, y0_out, x1_out, y1_out, color_out,
                           next_line.x0, next_line.y0, next_line.x1, next_line.y1,
                           next_line.color);
            end
        end
    end

    initial begin
        seed           = 32'h9882b6c6;
        errors         = 0;
        checks         = 0;
        lines_seen     = 0;
        lines_expected = 0;
        timed_out      = 1'b0;
        rst_n     = 1'b0;
        obj_valid = 1'b0;
        obj_shape = SHAPE_POINT;
        obj_color = '0;
        obj_x0 = '0;
        obj_y0 = '0;
        obj_x1 = '0;
        obj_y1 = '0;
        obj_x2 = '0;
        obj_y2 = '0;
        obj_x3 = '0;
        obj_y3 = '0;
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;

        run_test("inside points", 0, 6, 0);
        run_test("inside triangles and quads", 1, 10, 0);
        run_test("shared outside region", 2, 12, 0);
        run_test("window crossings", 3, 30, 0);
        run_test("random objects", 4, 200, 5);

        $display("%0d checks, %0d errors, %0d lines seen", checks, errors, lines_seen);
        if (errors == 0 && !timed_out)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/clip_geom_pkg.sv
hdl/clip_ctrl_pkg.sv
hdl/shape_splitter.sv
hdl/seq_divider.sv
hdl/endpoint_clipper.sv
hdl/line_combiner.sv
hdl/clip_top.sv
tests/tb_clk_gen.sv
tests/clip_assertions.sv
tests/clip_tb.sv

//--- run.sh
#!/bin/sh
# build and run the clipping testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module clip_tb -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vclip_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
